//--- bpu_consts.svh
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// datapath width
`define BPU_XLEN     32

// bimodal direction table, indexed by pc[9:1]
`define BHT_ENTRIES  512
`define BHT_IDX_W    9
`define BHT_INIT     2'b01       // weakly not taken

// branch target buffer, indexed by pc[9:2], tag pc[31:10]
`define BTB_ENTRIES  256
`define BTB_IDX_W    8
`define BTB_TAG_W    22

// return address stack
`define RAS_DEPTH    8
`define RAS_PTR_W    4           // holds 0..8
`define RAS_IDX_W    3

// rv32 control transfer opcodes
`define OPC_BRANCH   7'b1100011
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111

`endif

//--- bpu_pkg.sv
`include "bpu_consts.svh"

package bpu_pkg;

    typedef logic [`BPU_XLEN-1:0] xlen_t;

    // upper bit is the direction, 1 is weakly not taken
    typedef logic [1:0] ctr2_t;

    typedef enum logic [2:0] {
        kind_other,
        kind_branch,
        kind_jal,
        kind_call_jalr,     // jalr linking through x1 or x5
        kind_ret,           // jalr x0, 0(x1 or x5)
        kind_jalr
    } inst_kind_e;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one instruction word, three field layouts
    typedef union packed {
        b_type_t b;
        j_type_t j;
        i_type_t i;
    } inst_word_u;

endpackage

//--- inst_predecode.sv
`timescale 1ns/10ps
`include "bpu_consts.svh"

module inst_predecode (
    input  bpu_pkg::xlen_t      inst_i,
    input  bpu_pkg::xlen_t      pc_i,
    output bpu_pkg::inst_kind_e kind_o,
    output logic                is_call_o,
    output bpu_pkg::xlen_t      static_target_o
);
    import bpu_pkg::*;

    inst_word_u w;
    xlen_t      b_imm;
    xlen_t      j_imm;
    logic       rd_link;
    logic       rs1_link;
    logic       is_jal;

    assign w = inst_i;

    // sign-extended immediates, bit 0 always zero
    assign b_imm = {{20{w.b.imm12}}, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
    assign j_imm = {{12{w.j.imm20}}, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};

    // x1 (ra) and x5 (t0) are the link registers
    assign rd_link  = (w.i.rd == 5'd1) || (w.i.rd == 5'd5);
    assign rs1_link = (w.i.rs1 == 5'd1) || (w.i.rs1 == 5'd5);
    assign is_jal   = (w.j.opcode == `OPC_JAL);

    always_comb begin
        case (w.i.opcode)
            `OPC_BRANCH: kind_o = kind_branch;
            `OPC_JAL:    kind_o = kind_jal;
            `OPC_JALR: begin
                if (rd_link)
                    kind_o = kind_call_jalr;     // a linking jalr counts as a call first
                else if (w.i.rd == 5'd0 && rs1_link && w.i.imm == 12'd0)
                    kind_o = kind_ret;
                else
                    kind_o = kind_jalr;
            end
            default:     kind_o = kind_other;
        endcase
    end

    assign is_call_o = (is_jal && rd_link) || (kind_o == kind_call_jalr);

    // only meaningful for jal and branches
    assign static_target_o = pc_i + (is_jal ? j_imm : b_imm);

endmodule

//--- bimodal_table.sv
`timescale 1ns/10ps
`include "bpu_consts.svh"

module bimodal_table (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::xlen_t rd_pc_i,
    output logic           rd_taken_o,
    input  logic           wr_en_i,
    input  bpu_pkg::xlen_t wr_pc_i,
    input  logic           wr_taken_i
);
    import bpu_pkg::*;

    ctr2_t                 ctr_q [`BHT_ENTRIES];
    logic [`BHT_IDX_W-1:0] rd_idx;
    logic [`BHT_IDX_W-1:0] wr_idx;

    assign rd_idx = rd_pc_i[`BHT_IDX_W:1];
    assign wr_idx = wr_pc_i[`BHT_IDX_W:1];

    assign rd_taken_o = ctr_q[rd_idx][1];   // msb is the direction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                ctr_q[i] <= `BHT_INIT;
            end
        end else if (wr_en_i) begin
            // one step toward the outcome, saturate at 0 and 3
            if (wr_taken_i && ctr_q[wr_idx] != 2'b11)
                ctr_q[wr_idx] <= ctr_q[wr_idx] + 2'd1;
            else if (!wr_taken_i && ctr_q[wr_idx] != 2'b00)
                ctr_q[wr_idx] <= ctr_q[wr_idx] - 2'd1;
        end
    end

endmodule

//--- btb.sv
`timescale 1ns/10ps
`include "bpu_consts.svh"

module btb (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::xlen_t rd_pc_i,
    output logic           hit_o,
    output bpu_pkg::xlen_t target_o,
    input  logic           wr_en_i,
    input  bpu_pkg::xlen_t wr_pc_i,
    input  bpu_pkg::xlen_t wr_target_i
);
    import bpu_pkg::*;

    logic [`BTB_TAG_W-1:0]   tag_q [`BTB_ENTRIES];
    xlen_t                   tgt_q [`BTB_ENTRIES];
    logic [`BTB_ENTRIES-1:0] valid_q;

    logic [`BTB_IDX_W-1:0] rd_idx;
    logic [`BTB_IDX_W-1:0] wr_idx;
    logic [`BTB_TAG_W-1:0] rd_tag;
    logic [`BTB_TAG_W-1:0] wr_tag;

    assign rd_idx = rd_pc_i[`BTB_IDX_W+1:2];
    assign wr_idx = wr_pc_i[`BTB_IDX_W+1:2];
    assign rd_tag = rd_pc_i[`BPU_XLEN-1:`BPU_XLEN-`BTB_TAG_W];
    assign wr_tag = wr_pc_i[`BPU_XLEN-1:`BPU_XLEN-`BTB_TAG_W];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = tgt_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            valid_q <= '0;
        else if (wr_en_i)
            valid_q[wr_idx] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[wr_idx] <= wr_tag;        // replaces whatever aliased here
            tgt_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

//--- ras_stack.sv
`timescale 1ns/10ps
`include "bpu_consts.svh"

module ras_stack (
    input  logic           clk,
    input  logic           rst,
    input  logic           push_i,
    input  bpu_pkg::xlen_t push_data_i,
    input  logic           pop_i,
    output bpu_pkg::xlen_t top_o,
    output logic           empty_o
);
    import bpu_pkg::*;

    localparam logic [`RAS_PTR_W-1:0] ptr_one  = 1;
    localparam logic [`RAS_PTR_W-1:0] ptr_full = `RAS_DEPTH;

    xlen_t                 stack_q [`RAS_DEPTH];
    logic [`RAS_PTR_W-1:0] ptr_q;       // next free slot
    logic [`RAS_PTR_W-1:0] top_ptr;
    logic [`RAS_PTR_W-1:0] ptr_pop;
    logic                  pop_ok;
    logic                  push_ok;

    assign empty_o = (ptr_q == '0);
    assign top_ptr = ptr_q - ptr_one;
    assign top_o   = stack_q[top_ptr[`RAS_IDX_W-1:0]];

    // pop is applied before push in the same cycle
    assign pop_ok  = pop_i && !empty_o;
    assign ptr_pop = pop_ok ? top_ptr : ptr_q;
    assign push_ok = push_i && (ptr_pop != ptr_full);  // full stack drops the push

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ptr_q <= '0;
        else if (push_ok)
            ptr_q <= ptr_pop + ptr_one;
        else
            ptr_q <= ptr_pop;
    end

    always_ff @(posedge clk) begin
        if (push_ok)
            stack_q[ptr_pop[`RAS_IDX_W-1:0]] <= push_data_i;
    end

endmodule

//--- bpu_ctrl.sv
`timescale 1ns/10ps

module bpu_ctrl (
    input  logic                clk,
    input  logic                rst,

    // update handshake
    input  logic                upd_req_i,
    output logic                upd_ack_o,
    input  bpu_pkg::inst_kind_e upd_kind_i,
    input  logic                upd_is_call_i,
    input  logic                upd_taken_i,

    // fetch side lookups
    input  bpu_pkg::xlen_t      fetch_pc_i,
    input  bpu_pkg::inst_kind_e fetch_kind_i,
    input  bpu_pkg::xlen_t      fetch_target_i,
    input  logic                bht_taken_i,
    input  logic                btb_hit_i,
    input  bpu_pkg::xlen_t      btb_target_i,
    input  bpu_pkg::xlen_t      ras_top_i,
    input  logic                ras_empty_i,

    output logic                pred_ctrl_o,
    output logic                pred_taken_o,
    output bpu_pkg::xlen_t      pred_pc_o,

    // table write enables
    output logic                bht_wr_o,
    output logic                btb_wr_o,
    output logic                ras_push_o,
    output logic                ras_pop_o
);
    import bpu_pkg::*;

    localparam logic st_idle = 1'b0;
    localparam logic st_ack  = 1'b1;

    logic  state_q;
    logic  upd_fire;
    xlen_t pc_plus4;

    // idle -> ack on a request, ack -> idle once req drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state_q <= st_idle;
        else if (state_q == st_idle && upd_req_i)
            state_q <= st_ack;
        else if (state_q == st_ack && !upd_req_i)
            state_q <= st_idle;
    end

    assign upd_ack_o = (state_q == st_ack);

    // high only in the cycle ending in the ack-rise edge
    assign upd_fire   = upd_req_i && (state_q == st_idle);
    assign bht_wr_o   = upd_fire && (upd_kind_i == kind_branch);
    assign btb_wr_o   = upd_fire && upd_taken_i;
    assign ras_push_o = upd_fire && upd_is_call_i;
    assign ras_pop_o  = upd_fire && upd_taken_i && (upd_kind_i == kind_ret);

    assign pc_plus4 = fetch_pc_i + 32'd4;

    always_comb begin
        pred_ctrl_o  = (fetch_kind_i != kind_other);
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_plus4;
        case (fetch_kind_i)
            kind_branch: begin
                pred_taken_o = bht_taken_i;
                if (bht_taken_i)
                    pred_pc_o = btb_hit_i ? btb_target_i : fetch_target_i;
            end
            kind_jal: begin
                pred_taken_o = 1'b1;
                pred_pc_o    = btb_hit_i ? btb_target_i : fetch_target_i;
            end
            kind_ret: begin
                if (!ras_empty_i) begin     // empty stack falls through to pc+4
                    pred_taken_o = 1'b1;
                    pred_pc_o    = ras_top_i;
                end
            end
            default: ;                      // other jalr forms are not predicted
        endcase
    end

endmodule

//--- bpu_top.sv
`timescale 1ns/10ps

module bpu_top (
    input  logic           clk,
    input  logic           rst,

    input  bpu_pkg::xlen_t fetch_pc_i,
    input  bpu_pkg::xlen_t fetch_inst_i,
    output logic           pred_ctrl_o,
    output logic           pred_taken_o,
    output bpu_pkg::xlen_t pred_pc_o,

    input  logic           upd_req_i,
    input  bpu_pkg::xlen_t upd_pc_i,
    input  bpu_pkg::xlen_t upd_inst_i,
    input  logic           upd_taken_i,
    input  bpu_pkg::xlen_t upd_target_i,
    output logic           upd_ack_o
);
    import bpu_pkg::*;

    inst_kind_e fetch_kind;
    xlen_t      fetch_target;
    inst_kind_e upd_kind;
    logic       upd_is_call;
    logic       bht_taken;
    logic       btb_hit;
    xlen_t      btb_target;
    xlen_t      ras_top;
    logic       ras_empty;
    logic       bht_wr;
    logic       btb_wr;
    logic       ras_push;
    logic       ras_pop;
    xlen_t      upd_ret_addr;

    assign upd_ret_addr = upd_pc_i + 32'd4;     // link address of a call

    inst_predecode u_fetch_dec (
        .inst_i(fetch_inst_i), .pc_i(fetch_pc_i), .kind_o(fetch_kind),
        .is_call_o(), .static_target_o(fetch_target)
    );

    // update side only needs the kind and call flag
    inst_predecode u_upd_dec (
        .inst_i(upd_inst_i), .pc_i(upd_pc_i), .kind_o(upd_kind),
        .is_call_o(upd_is_call), .static_target_o()
    );

    bimodal_table u_bht (
        .clk(clk), .rst(rst), .rd_pc_i(fetch_pc_i), .rd_taken_o(bht_taken),
        .wr_en_i(bht_wr), .wr_pc_i(upd_pc_i), .wr_taken_i(upd_taken_i)
    );

    btb u_btb (
        .clk(clk), .rst(rst), .rd_pc_i(fetch_pc_i), .hit_o(btb_hit),
        .target_o(btb_target), .wr_en_i(btb_wr), .wr_pc_i(upd_pc_i),
        .wr_target_i(upd_target_i)
    );

    ras_stack u_ras (
        .clk(clk), .rst(rst), .push_i(ras_push), .push_data_i(upd_ret_addr),
        .pop_i(ras_pop), .top_o(ras_top), .empty_o(ras_empty)
    );

    bpu_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .upd_req_i(upd_req_i), .upd_ack_o(upd_ack_o), .upd_kind_i(upd_kind),
        .upd_is_call_i(upd_is_call), .upd_taken_i(upd_taken_i),
        .fetch_pc_i(fetch_pc_i), .fetch_kind_i(fetch_kind),
        .fetch_target_i(fetch_target), .bht_taken_i(bht_taken),
        .btb_hit_i(btb_hit), .btb_target_i(btb_target),
        .ras_top_i(ras_top), .ras_empty_i(ras_empty),
        .pred_ctrl_o(pred_ctrl_o), .pred_taken_o(pred_taken_o), .pred_pc_o(pred_pc_o),
        .bht_wr_o(bht_wr), .btb_wr_o(btb_wr), .ras_push_o(ras_push), .ras_pop_o(ras_pop)
    );

endmodule

//--- tb_bpu.sv
`timescale 1ns/10ps
`include "bpu_consts.svh"

module tb_bpu;
    import bpu_pkg::*;

    typedef struct packed {
        logic  ctrl;
        logic  taken;
        xlen_t pc;
    } pred_t;

    // update count summed over all tests below
    localparam int n_updates   = 323;
    localparam int cycle_limit = 6 * n_updates + 200;

    logic  clk;
    logic  rst;
    xlen_t fetch_pc_i;
    xlen_t fetch_inst_i;
    xlen_t upd_pc_i;
    xlen_t upd_inst_i;
    xlen_t upd_target_i;
    xlen_t pred_pc_o;
    logic  upd_req_i;
    logic  upd_taken_i;
    logic  upd_ack_o;
    logic  pred_ctrl_o;
    logic  pred_taken_o;

    // reference copies of the tables
    ctr2_t                 bht_m [`BHT_ENTRIES];
    logic                  btb_v [`BTB_ENTRIES];
    logic [`BTB_TAG_W-1:0] btb_tag [`BTB_ENTRIES];
    xlen_t                 btb_tgt [`BTB_ENTRIES];
    xlen_t                 ras_m [`RAS_DEPTH];
    int                    ras_n = 0;

    int err_cnt   = 0;
    int test_base = 0;
    int n_tests   = 0;
    int n_bad     = 0;
    int ack_rises = 0;
    int cycles    = 0;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    bpu_top UUT (
        .clk(clk), .rst(rst),
        .fetch_pc_i(fetch_pc_i), .fetch_inst_i(fetch_inst_i), .pred_ctrl_o(pred_ctrl_o),
        .pred_taken_o(pred_taken_o), .pred_pc_o(pred_pc_o),
        .upd_req_i(upd_req_i), .upd_pc_i(upd_pc_i), .upd_inst_i(upd_inst_i),
        .upd_taken_i(upd_taken_i), .upd_target_i(upd_target_i), .upd_ack_o(upd_ack_o)
    );

    task automatic check_taken(logic got, logic exp, string what);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(xlen_t got, xlen_t exp, string what);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // instruction encoders
    function automatic xlen_t enc_b(logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'd0, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic xlen_t enc_j(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    function automatic xlen_t enc_jalr(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'd0, rd, `OPC_JALR};
    endfunction

    function automatic inst_kind_e kind_ref(xlen_t w);
        logic rd_link;
        logic rs1_link;
        rd_link  = (w[11:7] == 5'd1) || (w[11:7] == 5'd5);
        rs1_link = (w[19:15] == 5'd1) || (w[19:15] == 5'd5);
        case (w[6:0])
            `OPC_BRANCH: return kind_branch;
            `OPC_JAL:    return kind_jal;
            `OPC_JALR: begin
                if (rd_link)
                    return kind_call_jalr;
                else if (w[11:7] == 5'd0 && rs1_link && w[31:20] == 12'd0)
                    return kind_ret;
                else
                    return kind_jalr;
            end
            default:     return kind_other;
        endcase
    endfunction

    function automatic pred_t predict_ref(xlen_t pc, xlen_t w);
        pred_t      p;
        inst_kind_e k;
        logic       hit;
        xlen_t      b_off;
        xlen_t      j_off;
        k     = kind_ref(w);
        hit   = btb_v[pc[9:2]] && (btb_tag[pc[9:2]] == pc[31:10]);
        b_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        j_off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        p.ctrl  = (k != kind_other);
        p.taken = 1'b0;
        p.pc    = pc + 32'd4;
        if (k == kind_branch && bht_m[pc[9:1]][1]) begin
            p.taken = 1'b1;
            p.pc    = hit ? btb_tgt[pc[9:2]] : pc + b_off;
        end else if (k == kind_jal) begin
            p.taken = 1'b1;
            p.pc    = hit ? btb_tgt[pc[9:2]] : pc + j_off;
        end else if (k == kind_ret && ras_n > 0) begin
            p.taken = 1'b1;
            p.pc    = ras_m[ras_n-1];
        end
        return p;
    endfunction

    // model follows the update rule at each ack rise
    always @(posedge upd_ack_o) begin : model_update
        inst_kind_e k;
        logic       link;
        k    = kind_ref(upd_inst_i);
        link = (upd_inst_i[11:7] == 5'd1) || (upd_inst_i[11:7] == 5'd5);
        ack_rises++;
        if (k == kind_branch && upd_taken_i && bht_m[upd_pc_i[9:1]] != 2'd3)
            bht_m[upd_pc_i[9:1]]++;
        else if (k == kind_branch && !upd_taken_i && bht_m[upd_pc_i[9:1]] != 2'd0)
            bht_m[upd_pc_i[9:1]]--;
        if (upd_taken_i) begin
            btb_v[upd_pc_i[9:2]]   = 1'b1;
            btb_tag[upd_pc_i[9:2]] = upd_pc_i[31:10];
            btb_tgt[upd_pc_i[9:2]] = upd_target_i;
        end
        if (k == kind_ret && upd_taken_i && ras_n > 0)
            ras_n--;                                // pop before push
        if (((k == kind_jal && link) || k == kind_call_jalr) && ras_n < `RAS_DEPTH) begin
            ras_m[ras_n] = upd_pc_i + 32'd4;
            ras_n++;
        end
    end

    // compared every cycle out of reset
    always @(posedge clk) begin : compare_pred
        pred_t exp;
        if (!rst) begin
            exp = predict_ref(fetch_pc_i, fetch_inst_i);
            check_taken(pred_ctrl_o, exp.ctrl, "pred_ctrl vs model");
            check_taken(pred_taken_o, exp.taken, "pred_taken vs model");
            check_pc(pred_pc_o, exp.pc, "pred_pc vs model");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // full four-phase handshake with req optionally held longer
    task automatic do_update(xlen_t pc, xlen_t inst, logic taken, xlen_t target, int hold);
        @(negedge clk);
        while (upd_ack_o)
            @(negedge clk);
        upd_pc_i     = pc;
        upd_inst_i   = inst;
        upd_taken_i  = taken;
        upd_target_i = target;
        upd_req_i    = 1'b1;
        @(negedge clk);
        while (!upd_ack_o)
            @(negedge clk);
        repeat (hold) begin
            @(negedge clk);
            check_taken(upd_ack_o, 1'b1, "ack while req held");
        end
        upd_req_i = 1'b0;
        @(negedge clk);
        while (upd_ack_o)
            @(negedge clk);
    endtask

    task automatic expect_pred(xlen_t pc, xlen_t inst, logic taken, xlen_t tgt, string what);
        @(negedge clk);
        fetch_pc_i   = pc;
        fetch_inst_i = inst;
        @(posedge clk);
        check_taken(pred_taken_o, taken, what);
        check_pc(pred_pc_o, tgt, what);
    endtask

    task automatic end_test(string name);
        n_tests++;
        if (err_cnt == test_base) begin
            $display("test %-10s ok", name);
        end else begin
            n_bad++;
            $display("test %-10s %0d errors", name, err_cnt - test_base);
        end
        test_base = err_cnt;
    endtask

    function automatic xlen_t rand_inst();
        logic [4:0] link;
        link = ($urandom % 2) ? 5'd1 : 5'd5;
        case ($urandom % 7)
            0:       return enc_b(13'($urandom));
            1:       return enc_j(link, 21'($urandom));     // call
            2:       return enc_j(5'd0, 21'($urandom));
            3:       return enc_jalr(5'd0, link, 12'd0);    // ret
            4:       return enc_jalr(link, 5'($urandom), 12'($urandom));
            5:       return enc_jalr(5'd7, 5'd2, 12'($urandom));
            default: return $urandom;
        endcase
    endfunction

    initial begin
        int unsigned seed_r;
        xlen_t       pc;
        xlen_t       inst;
        int          rises0;
        seed_r       = $urandom(14286);
        rst          = 1'b1;
        fetch_pc_i   = '0;
        fetch_inst_i = 32'h0000_0013;
        upd_req_i    = 1'b0;
        upd_pc_i     = '0;
        upd_inst_i   = '0;
        upd_taken_i  = 1'b0;
        upd_target_i = '0;
        for (int i = 0; i < `BHT_ENTRIES; i++)
            bht_m[i] = 2'b01;                       // weakly not taken
        for (int i = 0; i < `BTB_ENTRIES; i++)
            btb_v[i] = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_taken(upd_ack_o, 1'b0, "ack after reset");
        expect_pred(32'h100, 32'h0000_0013, 1'b0, 32'h104, "non-control");
        expect_pred(32'h200, enc_b(13'd16), 1'b0, 32'h204, "untrained branch");
        end_test("reset");

        repeat (2) do_update(32'h200, enc_b(13'd16), 1'b1, 32'h2a0, 0);
        expect_pred(32'h200, enc_b(13'd16), 1'b1, 32'h2a0, "trained branch");
        repeat (3) do_update(32'h200, enc_b(13'd16), 1'b0, 32'h204, 0);
        expect_pred(32'h200, enc_b(13'd16), 1'b0, 32'h204, "untrained again");
        end_test("training");

        expect_pred(32'h300, enc_j(5'd0, 21'h40), 1'b1, 32'h340, "jal offset");
        do_update(32'h300, enc_j(5'd0, 21'h40), 1'b1, 32'h1234_5670, 0);
        expect_pred(32'h300, enc_j(5'd0, 21'h40), 1'b1, 32'h1234_5670, "jal btb hit");
        expect_pred(32'h700, enc_j(5'd0, 21'h40), 1'b1, 32'h740, "jal tag miss");
        end_test("btb");

        for (int i = 0; i < 3; i++)
            do_update(32'h1000 + 32'(i) * 32'h100, enc_j(5'd1, 21'h80), 1'b1, 32'h5000, 0);
        for (int i = 2; i >= 0; i--) begin
            pc = 32'h1004 + 32'(i) * 32'h100;        // link address of call i
            expect_pred(32'h2000, enc_jalr(5'd0, 5'd1, 12'd0), 1'b1, pc, "ret lifo");
            do_update(32'h2000, enc_jalr(5'd0, 5'd1, 12'd0), 1'b1, pc, 0);
        end
        expect_pred(32'h2000, enc_jalr(5'd0, 5'd1, 12'd0), 1'b0, 32'h2004, "ret empty");
        for (int i = 0; i < 9; i++)
            do_update(32'h3000 + 32'(i) * 32'h10, enc_j(5'd5, 21'h80), 1'b1, 32'h8000, 0);
        expect_pred(32'h2000, enc_jalr(5'd0, 5'd5, 12'd0), 1'b1, 32'h3074, "ras overflow");
        end_test("ras");

        // two tags over a few indices so entries alias
        for (int i = 0; i < 300; i++) begin
            pc   = 32'h800 | (32'($urandom % 2) << 10) | (32'($urandom % 32) << 2);
            inst = rand_inst();
            @(negedge clk);
            fetch_pc_i   = pc;
            fetch_inst_i = inst;
            @(posedge clk);
            do_update(pc, inst, 1'($urandom), xlen_t'($urandom) & 32'hffff_fffc, 0);
        end
        end_test("random");

        // one held taken step then one plain not-taken step lands back on weakly not taken
        rises0 = ack_rises;
        do_update(32'h500, enc_b(13'd8), 1'b1, 32'h508, 4);
        if (ack_rises != rises0 + 1) begin
            err_cnt++;
            $display("[FAIL] %0t: ack rose %0d times for one request", $time, ack_rises - rises0);
        end
        expect_pred(32'h500, enc_b(13'd8), 1'b1, 32'h508, "held taken");
        do_update(32'h500, enc_b(13'd8), 1'b0, 32'h504, 0);
        expect_pred(32'h500, enc_b(13'd8), 1'b0, 32'h504, "single step");
        end_test("handshake");

        $display("tests %0d, failing tests %0d, failed checks %0d", n_tests, n_bad, err_cnt);
        if (err_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
bpu_pkg.sv
inst_predecode.sv
bimodal_table.sv
btb.sv
ras_stack.sv
bpu_ctrl.sv
bpu_top.sv
tb_bpu.sv
